// File: design/ntm_arith_pkg.sv
// Word width, word type and modular add helper, imported by the datapath modules
package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////
  // Word definitions
  ////////////////////////////////////////////////////////////

  // Default width, the top level passes its own value down
  localparam int DATA_SIZE = 32;

  // Unsigned residue word
  typedef logic [DATA_SIZE-1:0] word_t;

  ////////////////////////////////////////////////////////////
  // Modular helpers
  ////////////////////////////////////////////////////////////

  // Sum of two residues, reduced once by the modulus
  // Both inputs must already be below m
  function automatic word_t mod_add(input word_t a, input word_t b, input word_t m);
    logic [DATA_SIZE:0] sum;
    // Extra bit keeps the carry
    sum = {1'b0, a} + {1'b0, b};
    if (sum >= {1'b0, m}) begin
      sum = sum - {1'b0, m};
    end
    return sum[DATA_SIZE-1:0];
  endfunction

endpackage

// File: design/ntm_ctrl_pkg.sv
// Sequencing state encodings, imported by the element capture FSMs
package ntm_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Element sequencing
  ////////////////////////////////////////////////////////////

  // Idle until START, input while collecting operands,
  // finish while the element result is produced
  typedef enum logic [1:0] {
    STATE_IDLE   = 2'd0,
    STATE_INPUT  = 2'd1,
    STATE_FINISH = 2'd2
  } seq_state_t;

endpackage

// File: design/ntm_scalar_multiplier.sv
// Bit-serial modular multiplier, START latches operands and READY pulses with the product
`timescale 1ns/100ps

module ntm_scalar_multiplier import ntm_arith_pkg::*; #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int IDX_W = $clog2(DATA_SIZE);

  // Latched operands
  logic [DATA_SIZE-1:0] a_reg;
  logic [DATA_SIZE-1:0] b_reg;
  logic [DATA_SIZE-1:0] mod_reg;
  // Running residue
  logic [DATA_SIZE-1:0] acc;
  logic [DATA_SIZE-1:0] acc_dbl;
  logic [DATA_SIZE-1:0] acc_next;
  // Current bit of B, top bit first
  logic [IDX_W-1:0]     bit_idx;
  logic                 busy;

  ////////////////////////////////////////////////////////////
  // One interleaved step, acc = 2*acc + b[i]*a mod m
  ////////////////////////////////////////////////////////////

  always_comb begin
    acc_dbl  = DATA_SIZE'(mod_add(word_t'(acc), word_t'(acc), word_t'(mod_reg)));
    acc_next = acc_dbl;
    if (b_reg[bit_idx]) begin
      acc_next = DATA_SIZE'(mod_add(word_t'(acc_dbl), word_t'(a_reg), word_t'(mod_reg)));
    end
  end

  // Operand capture and accumulator
  always_ff @(posedge CLK) begin
    if (START) begin
      a_reg   <= DATA_A_IN;
      b_reg   <= DATA_B_IN;
      mod_reg <= MODULO_IN;
      acc     <= '0;
    end else if (busy) begin
      acc <= acc_next;
    end
  end

  // Bit counter and result strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      bit_idx  <= '0;
      READY    <= 1'b0;
      DATA_OUT <= '0;
    end else begin
      READY <= 1'b0;
      if (START) begin
        busy    <= 1'b1;
        bit_idx <= IDX_W'(DATA_SIZE - 1);
      end else if (busy) begin
        if (bit_idx == '0) begin
          // Last bit, publish the residue
          busy     <= 1'b0;
          READY    <= 1'b1;
          DATA_OUT <= acc_next;
        end else begin
          bit_idx <= bit_idx - 1'b1;
        end
      end
    end
  end

endmodule

// File: design/ntm_vector_multiplier.sv
// Element-wise modular product stage, collects operand pairs and runs the scalar multiplier
`timescale 1ns/100ps

module ntm_vector_multiplier import ntm_ctrl_pkg::*; #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  logic                 DATA_A_IN_ENABLE,
  input  logic                 DATA_B_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic                 PRODUCT_ENABLE,
  output logic [DATA_SIZE-1:0] PRODUCT
);

  seq_state_t           state;

  // Arrival flags, one per operand
  logic                 a_held;
  logic                 b_held;
  // Operand and modulus holding registers
  logic [DATA_SIZE-1:0] a_reg;
  logic [DATA_SIZE-1:0] b_reg;
  logic [DATA_SIZE-1:0] mod_reg;

  // Scalar multiplier handshake
  logic                 start_scalar;
  logic                 ready_scalar;
  logic [DATA_SIZE-1:0] result_scalar;

  ////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (START) begin
      mod_reg <= MODULO_IN;
    end
    if (state == STATE_INPUT && DATA_A_IN_ENABLE) begin
      a_reg <= DATA_A_IN;
    end
    if (state == STATE_INPUT && DATA_B_IN_ENABLE) begin
      b_reg <= DATA_B_IN;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencing FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= STATE_IDLE;
      a_held         <= 1'b0;
      b_held         <= 1'b0;
      start_scalar   <= 1'b0;
      PRODUCT_ENABLE <= 1'b0;
      PRODUCT        <= '0;
    end else begin
      start_scalar   <= 1'b0;
      PRODUCT_ENABLE <= 1'b0;
      if (START) begin
        a_held <= 1'b0;
        b_held <= 1'b0;
        // Zero-length vector takes no elements
        state  <= (SIZE_IN != '0) ? STATE_INPUT : STATE_IDLE;
      end else begin
        case (state)
          STATE_INPUT: begin
            if (DATA_A_IN_ENABLE) begin
              a_held <= 1'b1;
            end
            if (DATA_B_IN_ENABLE) begin
              b_held <= 1'b1;
            end
            // Both operands in hand, kick the multiplier
            if (a_held && b_held) begin
              start_scalar <= 1'b1;
              a_held       <= 1'b0;
              b_held       <= 1'b0;
              state        <= STATE_FINISH;
            end
          end
          STATE_FINISH: begin
            if (ready_scalar) begin
              PRODUCT        <= result_scalar;
              PRODUCT_ENABLE <= 1'b1;
              state          <= STATE_INPUT;
            end
          end
          // Idle waits for START
          default: state <= STATE_IDLE;
        endcase
      end
    end
  end

  ntm_scalar_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) u_scalar_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start_scalar),
    .READY    (ready_scalar),
    .MODULO_IN(mod_reg),
    .DATA_A_IN(a_reg),
    .DATA_B_IN(b_reg),
    .DATA_OUT (result_scalar)
  );

endmodule

// File: design/ntm_vector_adder.sv
// Element-wise modular sum stage, collects operand pairs and adds them in one cycle
`timescale 1ns/100ps

module ntm_vector_adder import ntm_arith_pkg::*, ntm_ctrl_pkg::*; #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic                 DATA_A_IN_ENABLE,
  input  logic                 DATA_B_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic                 SUM_ENABLE,
  output logic [DATA_SIZE-1:0] SUM
);

  seq_state_t           state;
  logic                 a_held;
  logic                 b_held;
  logic [DATA_SIZE-1:0] a_reg;
  logic [DATA_SIZE-1:0] b_reg;
  logic [DATA_SIZE-1:0] mod_reg;

  // Operand capture, modulus on START
  always_ff @(posedge CLK) begin
    if (START) begin
      mod_reg <= MODULO_IN;
    end
    if (state == STATE_INPUT && DATA_A_IN_ENABLE) begin
      a_reg <= DATA_A_IN;
    end
    if (state == STATE_INPUT && DATA_B_IN_ENABLE) begin
      b_reg <= DATA_B_IN;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencing FSM, finish is the cycle with both held
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= STATE_IDLE;
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      SUM_ENABLE <= 1'b0;
      SUM        <= '0;
    end else begin
      SUM_ENABLE <= 1'b0;
      if (START) begin
        a_held <= 1'b0;
        b_held <= 1'b0;
        state  <= STATE_INPUT;
      end else begin
        case (state)
          STATE_INPUT: begin
            if (DATA_A_IN_ENABLE) begin
              a_held <= 1'b1;
            end
            if (DATA_B_IN_ENABLE) begin
              b_held <= 1'b1;
            end
            // Second operand lands now, both held next cycle
            if ((a_held || DATA_A_IN_ENABLE) && (b_held || DATA_B_IN_ENABLE)) begin
              state <= STATE_FINISH;
            end
          end
          STATE_FINISH: begin
            SUM        <= DATA_SIZE'(mod_add(word_t'(a_reg), word_t'(b_reg), word_t'(mod_reg)));
            SUM_ENABLE <= 1'b1;
            a_held     <= 1'b0;
            b_held     <= 1'b0;
            state      <= STATE_INPUT;
          end
          default: state <= STATE_IDLE;
        endcase
      end
    end
  end

endmodule

// File: design/ntm_vector_reducer.sv
// Pairs product and sum streams per element and accumulates inner product and total
`timescale 1ns/100ps

module ntm_vector_reducer import ntm_arith_pkg::*; #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  logic                 PRODUCT_ENABLE,
  input  logic [DATA_SIZE-1:0] PRODUCT,
  input  logic                 SUM_ENABLE,
  input  logic [DATA_SIZE-1:0] SUM,
  output logic                 DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] PRODUCT_OUT,
  output logic [DATA_SIZE-1:0] SUM_OUT,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DOT_OUT,
  output logic [DATA_SIZE-1:0] TOTAL_OUT
);

  // Result holding, whichever arrives first waits here
  logic [DATA_SIZE-1:0] prod_reg;
  logic [DATA_SIZE-1:0] sum_reg;
  logic                 prod_held;
  logic                 sum_held;
  // Vector parameters from START
  logic [DATA_SIZE-1:0] mod_reg;
  logic [DATA_SIZE-1:0] size_reg;
  // Element count and accumulators
  logic [DATA_SIZE-1:0] count;
  logic [DATA_SIZE-1:0] dot_acc;
  logic [DATA_SIZE-1:0] total_acc;
  logic [DATA_SIZE-1:0] dot_next;
  logic [DATA_SIZE-1:0] total_next;
  logic                 active;
  logic                 pair_ready;

  assign pair_ready = active && prod_held && sum_held;
  assign dot_next   = DATA_SIZE'(mod_add(word_t'(dot_acc), word_t'(prod_reg), word_t'(mod_reg)));
  assign total_next = DATA_SIZE'(mod_add(word_t'(total_acc), word_t'(sum_reg), word_t'(mod_reg)));

  always_ff @(posedge CLK) begin
    if (START) begin
      mod_reg  <= MODULO_IN;
      size_reg <= SIZE_IN;
    end
    if (PRODUCT_ENABLE) begin
      prod_reg <= PRODUCT;
    end
    if (SUM_ENABLE) begin
      sum_reg <= SUM;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pairing, accumulation and end of vector
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active          <= 1'b0;
      prod_held       <= 1'b0;
      sum_held        <= 1'b0;
      count           <= '0;
      dot_acc         <= '0;
      total_acc       <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      PRODUCT_OUT     <= '0;
      SUM_OUT         <= '0;
      DOT_OUT         <= '0;
      TOTAL_OUT       <= '0;
    end else begin
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      if (START) begin
        // New vector, drop earlier elements
        active    <= 1'b1;
        prod_held <= 1'b0;
        sum_held  <= 1'b0;
        count     <= '0;
        dot_acc   <= '0;
        total_acc <= '0;
      end else begin
        if (PRODUCT_ENABLE) begin
          prod_held <= 1'b1;
        end
        if (SUM_ENABLE) begin
          sum_held <= 1'b1;
        end
        if (pair_ready) begin
          prod_held       <= 1'b0;
          sum_held        <= 1'b0;
          DATA_OUT_ENABLE <= 1'b1;
          PRODUCT_OUT     <= prod_reg;
          SUM_OUT         <= sum_reg;
          dot_acc         <= dot_next;
          total_acc       <= total_next;
          if (count == size_reg - 1'b1) begin
            // Last element, READY rides on its strobe
            READY     <= 1'b1;
            DOT_OUT   <= dot_next;
            TOTAL_OUT <= total_next;
            active    <= 1'b0;
          end else begin
            count <= count + 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: design/ntm_vector_unit.sv
// Vector arithmetic unit top, the multiplier and adder engines feeding the reducer
`timescale 1ns/100ps

module ntm_vector_unit #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  logic                 DATA_A_IN_ENABLE,
  input  logic                 DATA_B_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic                 DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] PRODUCT_OUT,
  output logic [DATA_SIZE-1:0] SUM_OUT,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DOT_OUT,
  output logic [DATA_SIZE-1:0] TOTAL_OUT
);

  // Engine result streams
  logic                 product_enable;
  logic [DATA_SIZE-1:0] product;
  logic                 sum_enable;
  logic [DATA_SIZE-1:0] sum;

  // Product engine
  ntm_vector_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) u_multiplier (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .MODULO_IN       (MODULO_IN),
    .SIZE_IN         (SIZE_IN),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN       (DATA_B_IN),
    .PRODUCT_ENABLE  (product_enable),
    .PRODUCT         (product)
  );

  // Sum engine
  ntm_vector_adder #(
    .DATA_SIZE(DATA_SIZE)
  ) u_adder (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .MODULO_IN       (MODULO_IN),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN       (DATA_B_IN),
    .SUM_ENABLE      (sum_enable),
    .SUM             (sum)
  );

  ntm_vector_reducer #(
    .DATA_SIZE(DATA_SIZE)
  ) u_reducer (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .MODULO_IN      (MODULO_IN),
    .SIZE_IN        (SIZE_IN),
    .PRODUCT_ENABLE (product_enable),
    .PRODUCT        (product),
    .SUM_ENABLE     (sum_enable),
    .SUM            (sum),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .PRODUCT_OUT    (PRODUCT_OUT),
    .SUM_OUT        (SUM_OUT),
    .READY          (READY),
    .DOT_OUT        (DOT_OUT),
    .TOTAL_OUT      (TOTAL_OUT)
  );

endmodule

// File: test/ntm_clock_gen.sv
// Testbench clock and reset source, free-running clock with reset held for the first cycles
`timescale 1ns/100ps

module ntm_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic CLK,
  output logic RST
);

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Reset released just after the last reset edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 RST = 1'b0;
  end

endmodule

// File: test/ntm_vector_checker.sv
// Output checker for the vector unit, compares strobed results against queued expectations
`timescale 1ns/100ps

module ntm_vector_checker #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 DATA_OUT_ENABLE,
  input  logic [DATA_SIZE-1:0] PRODUCT_OUT,
  input  logic [DATA_SIZE-1:0] SUM_OUT,
  input  logic                 READY,
  input  logic [DATA_SIZE-1:0] DOT_OUT,
  input  logic [DATA_SIZE-1:0] TOTAL_OUT
);

  // Per-element expectations, in element order
  logic [DATA_SIZE-1:0] prod_q[$];
  logic [DATA_SIZE-1:0] sum_q[$];
  bit                   last_q[$];
  // End-of-vector expectations
  logic [DATA_SIZE-1:0] dot_q[$];
  logic [DATA_SIZE-1:0] total_q[$];

  int value_errors = 0;
  int other_errors = 0;

  function void expect_element(input logic [DATA_SIZE-1:0] prod,
                               input logic [DATA_SIZE-1:0] sum, input bit last);
    prod_q.push_back(prod);
    sum_q.push_back(sum);
    last_q.push_back(last);
  endfunction

  function void expect_result(input logic [DATA_SIZE-1:0] dot, input logic [DATA_SIZE-1:0] total);
    dot_q.push_back(dot);
    total_q.push_back(total);
  endfunction

  function void compare_word(input string name, input logic [DATA_SIZE-1:0] got,
                             input logic [DATA_SIZE-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endfunction

  // Anything still queued never showed up on the outputs
  function void final_check();
    if (prod_q.size() != 0) begin
      other_errors++;
      $display("%0d element results were expected but never strobed", prod_q.size());
    end
    if (dot_q.size() != 0) begin
      other_errors++;
      $display("%0d vector results were expected but READY never came", dot_q.size());
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Sampling at the rising edge, values from the last cycle
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin : compare_outputs
    bit last;
    if (!RST && DATA_OUT_ENABLE) begin
      if (prod_q.size() == 0) begin
        other_errors++;
        $display("DATA_OUT_ENABLE pulsed while no element was outstanding");
      end else begin
        compare_word("PRODUCT_OUT", PRODUCT_OUT, prod_q.pop_front());
        compare_word("SUM_OUT", SUM_OUT, sum_q.pop_front());
        last = last_q.pop_front();
        if (last && !READY) begin
          other_errors++;
          $display("READY missing on the last element of the vector");
        end
        if (!last && READY) begin
          other_errors++;
          $display("READY pulsed on an element before the last one");
        end
      end
    end
    // End of vector
    if (!RST && READY) begin
      if (dot_q.size() == 0) begin
        other_errors++;
        $display("READY pulsed while no vector result was outstanding");
      end else begin
        compare_word("DOT_OUT", DOT_OUT, dot_q.pop_front());
        compare_word("TOTAL_OUT", TOTAL_OUT, total_q.pop_front());
      end
    end
  end

endmodule

// File: test/ntm_vector_unit_props.sv
// Strobe and reset assertions, bound into the vector unit top by the testbench
`timescale 1ns/100ps

module ntm_vector_unit_props #(
  parameter int DATA_SIZE = 32
) (
  input logic                 CLK,
  input logic                 RST,
  input logic                 DATA_OUT_ENABLE,
  input logic                 READY,
  input logic [DATA_SIZE-1:0] PRODUCT_OUT,
  input logic [DATA_SIZE-1:0] SUM_OUT,
  input logic [DATA_SIZE-1:0] DOT_OUT,
  input logic [DATA_SIZE-1:0] TOTAL_OUT
);

  // Failure tally, read by the testbench at the end
  int failures = 0;

  // READY only rides on an element strobe
  ready_with_element: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else begin
      failures++;
      $error("READY asserted without DATA_OUT_ENABLE");
    end

  // Single-cycle pulses
  element_pulse: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else begin
      failures++;
      $error("DATA_OUT_ENABLE held longer than one cycle");
    end

  ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY)
    else begin
      failures++;
      $error("READY held longer than one cycle");
    end

  // Settled reset keeps every output quiet
  reset_quiet: assert property (@(posedge CLK)
    (RST && $past(RST)) |-> (!READY && !DATA_OUT_ENABLE && PRODUCT_OUT == '0
      && SUM_OUT == '0 && DOT_OUT == '0 && TOTAL_OUT == '0))
    else begin
      failures++;
      $error("Outputs active during reset");
    end

endmodule

// File: test/ntm_vector_unit_tb.sv
// Testbench top for the vector unit, runs random and edge vectors and prints the closing report
`timescale 1ns/100ps

module ntm_vector_unit_tb import ntm_arith_pkg::*; ();

  localparam int    RESET_TIMEOUT   = 50;
  localparam int    ELEMENT_TIMEOUT = 200;
  // Largest modulus the adders can take without overflow
  localparam word_t MAX_MOD         = {1'b0, {(DATA_SIZE-1){1'b1}}};

  logic  CLK;
  logic  RST;
  logic  start;
  logic  a_enable;
  logic  b_enable;
  word_t modulo;
  word_t size;
  word_t a_data;
  word_t b_data;
  logic  out_enable;
  logic  ready;
  word_t product_out;
  word_t sum_out;
  word_t dot_out;
  word_t total_out;

  int timeout_errors = 0;
  int total_errors;

  ntm_clock_gen #(
    .PERIOD_NS   (8),
    .RESET_CYCLES(3)
  ) u_clock_gen (
    .CLK(CLK),
    .RST(RST)
  );

  ntm_vector_unit #(
    .DATA_SIZE(DATA_SIZE)
  ) u_dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .MODULO_IN       (modulo),
    .SIZE_IN         (size),
    .DATA_A_IN_ENABLE(a_enable),
    .DATA_B_IN_ENABLE(b_enable),
    .DATA_A_IN       (a_data),
    .DATA_B_IN       (b_data),
    .DATA_OUT_ENABLE (out_enable),
    .PRODUCT_OUT     (product_out),
    .SUM_OUT         (sum_out),
    .READY           (ready),
    .DOT_OUT         (dot_out),
    .TOTAL_OUT       (total_out)
  );

  ntm_vector_checker #(
    .DATA_SIZE(DATA_SIZE)
  ) u_checker (
    .CLK            (CLK),
    .RST            (RST),
    .DATA_OUT_ENABLE(out_enable),
    .PRODUCT_OUT    (product_out),
    .SUM_OUT        (sum_out),
    .READY          (ready),
    .DOT_OUT        (dot_out),
    .TOTAL_OUT      (total_out)
  );

  bind ntm_vector_unit ntm_vector_unit_props #(
    .DATA_SIZE(DATA_SIZE)
  ) u_props (
    .CLK            (CLK),
    .RST            (RST),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .READY          (READY),
    .PRODUCT_OUT    (PRODUCT_OUT),
    .SUM_OUT        (SUM_OUT),
    .DOT_OUT        (DOT_OUT),
    .TOTAL_OUT      (TOTAL_OUT)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Full double-width product, then one remainder
  function automatic word_t ref_mod_mul(input word_t a, input word_t b, input word_t m);
    logic [2*DATA_SIZE-1:0] wide;
    wide = {{DATA_SIZE{1'b0}}, a} * {{DATA_SIZE{1'b0}}, b};
    return word_t'(wide % {{DATA_SIZE{1'b0}}, m});
  endfunction

  function automatic word_t ref_mod_add(input word_t a, input word_t b, input word_t m);
    logic [DATA_SIZE:0] wide;
    wide = {1'b0, a} + {1'b0, b};
    return word_t'(wide % {1'b0, m});
  endfunction

  // Cycles through zero, m-1 and one
  function automatic word_t edge_operand(input int idx, input word_t m);
    case (idx % 3)
      0:       return '0;
      1:       return m - 1'b1;
      default: return word_t'(1);
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Host side tasks
  ////////////////////////////////////////////////////////////

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (RST && cycles < RESET_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (RST) begin
      timeout_errors++;
      $display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
    end
  endtask

  task automatic start_vector(input word_t m, input word_t n);
    @(posedge CLK);
    #1;
    start  = 1'b1;
    modulo = m;
    size   = n;
    @(posedge CLK);
    #1;
    start = 1'b0;
  endtask

  // Order 0 both at once, 1 A leads, 2 B leads, gap in cycles
  task automatic drive_pair(input word_t a, input word_t b, input int order, input int gap);
    @(posedge CLK);
    #1;
    a_data   = a;
    b_data   = b;
    a_enable = (order != 2);
    b_enable = (order != 1);
    @(posedge CLK);
    #1;
    a_enable = 1'b0;
    b_enable = 1'b0;
    if (order != 0) begin
      repeat (gap - 1) begin
        @(posedge CLK);
        #1;
      end
      a_enable = (order == 2);
      b_enable = (order == 1);
      @(posedge CLK);
      #1;
      a_enable = 1'b0;
      b_enable = 1'b0;
    end
  endtask

  task automatic wait_element_done();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!out_enable && cycles < ELEMENT_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!out_enable) begin
      timeout_errors++;
      $display("Timeout: no element strobe within %0d cycles", ELEMENT_TIMEOUT);
    end
  endtask

  // One whole vector, expectations queued before each element goes in
  task automatic run_vector(input word_t m, input int n, input bit edge_ops);
    word_t a;
    word_t b;
    word_t p;
    word_t s;
    word_t dot;
    word_t total;
    int    order;
    int    gap;
    dot   = '0;
    total = '0;
    start_vector(m, word_t'(n));
    for (int i = 0; i < n; i++) begin
      if (edge_ops) begin
        a = edge_operand(i, m);
        // B slips one step every third element, so equal edge values also meet
        b = edge_operand(i + i / 3, m);
      end else begin
        a = word_t'($urandom) % m;
        b = word_t'($urandom) % m;
      end
      order = $urandom % 3;
      gap   = 1 + $urandom % 4;
      p     = ref_mod_mul(a, b, m);
      s     = ref_mod_add(a, b, m);
      dot   = ref_mod_add(dot, p, m);
      total = ref_mod_add(total, s, m);
      u_checker.expect_element(p, s, i == n - 1);
      if (i == n - 1) begin
        u_checker.expect_result(dot, total);
      end
      drive_pair(a, b, order, gap);
      wait_element_done();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    word_t m;
    int    n;
    void'($urandom(27));
    start    = 1'b0;
    a_enable = 1'b0;
    b_enable = 1'b0;
    modulo   = '0;
    size     = '0;
    a_data   = '0;
    b_data   = '0;
    wait_reset_release();
    // Idle stretch, checker flags any stray strobe
    repeat (6) @(posedge CLK);
    run_vector(word_t'(1000003), 1, 1'b0);
    // Random lengths and moduli, mixed strobe order
    for (int v = 0; v < 12; v++) begin
      m = 2 + word_t'($urandom) % (MAX_MOD - 1'b1);
      n = 2 + $urandom % 7;
      run_vector(m, n, 1'b0);
    end
    // Edge operands, largest and smallest moduli
    run_vector(MAX_MOD, 5, 1'b1);
    run_vector(word_t'(2), 4, 1'b1);
    run_vector(MAX_MOD, 3, 1'b0);
    // Fresh START after READY, one element alone in the sums
    run_vector(word_t'(97), 1, 1'b0);
    repeat (4) @(posedge CLK);
    u_checker.final_check();
    total_errors = u_checker.value_errors + u_checker.other_errors + timeout_errors
                   + u_dut.u_props.failures;
    $display("Errors: %0d value, %0d protocol, %0d timeout, %0d assertion",
             u_checker.value_errors, u_checker.other_errors, timeout_errors,
             u_dut.u_props.failures);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
design/ntm_arith_pkg.sv
design/ntm_ctrl_pkg.sv
design/ntm_scalar_multiplier.sv
design/ntm_vector_multiplier.sv
design/ntm_vector_adder.sv
design/ntm_vector_reducer.sv
design/ntm_vector_unit.sv
test/ntm_clock_gen.sv
test/ntm_vector_checker.sv
test/ntm_vector_unit_props.sv
test/ntm_vector_unit_tb.sv

// File: run.sh
#!/bin/sh
# Builds the vector unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module ntm_vector_unit_tb -o ntm_vector_unit_sim

out=$(./obj_dir/ntm_vector_unit_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'
